// ==== logic/flush_pkg.sv ====
// Shared types and sizes for the flush slice; import into any block that needs them

package flush_pkg;

    // ------------------------------
    // Core geometry
    // ------------------------------

    // Address and PC width
    localparam int unsigned XLEN = 32;

    // ------------------------------
    // Data cache
    // ------------------------------

    // One dirty bit per set, walked in order on a flush
    localparam int unsigned DCACHE_SETS  = 16;
    localparam int unsigned DCACHE_IDX_W = $clog2(DCACHE_SETS); // Set index width

    // ------------------------------
    // Write-back port
    // ------------------------------

    // Credits held by the engine right after reset
    localparam int unsigned WB_CREDITS = 2;

    // Counter must hold 0 up to WB_CREDITS inclusive
    localparam int unsigned WB_CNT_W = $clog2(WB_CREDITS + 1);

    // ------------------------------
    // Branch resolution record
    // ------------------------------

    // Registered outcome of a resolved branch
    // valid          record holds a branch seen last cycle
    // is_mispredict  front-end followed the wrong path
    // pc             address of the branch itself
    typedef struct packed {
        logic            valid;         // Branch resolved
        logic            is_mispredict; // Wrong direction or wrong target
        logic [XLEN-1:0] pc;            // Branch PC
    } bp_resolve_t;

endpackage

// ==== logic/flush_bus_if.sv ====
// Stage and structure flush commands from the flush controller to their consumers
`timescale 1ns/100ps

interface flush_bus_if;

    logic set_pc_commit;        // PC gen takes the PC from commit
    logic flush_if;             // Kill the fetch stage
    logic flush_unissued_instr; // Drop instructions not yet issued
    logic flush_id;             // Kill decode
    logic flush_ex;             // Kill execute
    logic flush_bp;             // Clear the branch predictor
    logic flush_icache;         // Invalidate the icache
    logic flush_tlb;            // Invalidate the TLBs

    // Controller side, drives every command
    modport ctrl (
        output set_pc_commit, flush_if, flush_unissued_instr, flush_id,
        output flush_ex, flush_bp, flush_icache, flush_tlb
    );

    // Consumer side, level commands valid in the cycle they are high
    modport sink (
        input set_pc_commit, flush_if, flush_unissued_instr, flush_id,
        input flush_ex, flush_bp, flush_icache, flush_tlb
    );

endinterface

// ==== logic/branch_resolve_unit.sv ====
// Checks a resolved branch against its prediction and registers the outcome for the flush controller
`timescale 1ns/100ps

module branch_resolve_unit (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     resolve_valid_i,    // Branch resolves this cycle
    input  logic [flush_pkg::XLEN-1:0] pc_i,             // PC of the branch
    input  logic                     predicted_taken_i,  // Direction the front-end took
    input  logic                     actual_taken_i,     // Direction from the ALU
    input  logic [flush_pkg::XLEN-1:0] predicted_target_i,
    input  logic [flush_pkg::XLEN-1:0] actual_target_i,
    output flush_pkg::bp_resolve_t   resolved_branch_o   // One cycle after resolve_valid_i
);

    import flush_pkg::*;

    logic            dir_miss;    // Taken direction differs
    logic            target_miss; // Both taken but jumped to the wrong place
    logic            mispredict;
    logic            valid_q;
    logic            mispredict_q;
    logic [XLEN-1:0] pc_q;

    // ------------------------------
    // Compare
    // ------------------------------
    assign dir_miss    = predicted_taken_i != actual_taken_i;
    assign target_miss = predicted_taken_i && actual_taken_i
                         && (predicted_target_i != actual_target_i);
    assign mispredict  = resolve_valid_i && (dir_miss || target_miss);

    // ------------------------------
    // Record stage
    // ------------------------------
    // Keeps the execute comparators off the flush decode path
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q      <= 1'b0;
            mispredict_q <= 1'b0;
        end else begin
            valid_q      <= resolve_valid_i;
            mispredict_q <= mispredict;
        end
    end

    // Branch PC travels with the record
    always_ff @(posedge clk_i) begin
        if (resolve_valid_i) pc_q <= pc_i; // Hold last branch PC otherwise
    end

    assign resolved_branch_o = '{valid: valid_q, is_mispredict: mispredict_q, pc: pc_q};

endmodule

// ==== logic/flush_ctrl.sv ====
// Flush controller: decodes pipeline events into flush commands, runs fences and drives the halt
`timescale 1ns/100ps

module flush_ctrl (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  flush_pkg::bp_resolve_t resolved_branch_i,  // Registered branch outcome
    input  logic                   fence_i,            // fence committed
    input  logic                   fence_i_i,          // fence.i committed
    input  logic                   sfence_vma_i,       // sfence.vma committed
    input  logic                   flush_csr_i,        // CSR write with side effects
    input  logic                   flush_commit_i,     // Commit stage asks for a flush
    input  logic                   ex_valid_i,         // Exception taken
    input  logic                   eret_i,             // Return from trap
    input  logic                   set_debug_pc_i,     // Debug mode entry
    input  logic                   halt_csr_i,         // WFI style halt
    input  logic                   halt_acc_i,         // Accelerator halt
    input  logic                   flush_dcache_ack_i, // Dcache walk done, one cycle pulse
    flush_bus_if.ctrl              flush_bus,
    output logic                   flush_dcache_o,     // Held until the acknowledge
    output logic                   halt_o              // Stall commit
);

    logic fence_active_d;
    logic fence_active_q; // Dcache flush in flight
    logic flush_dcache_d;
    logic mispredict;     // Front-end went the wrong way
    logic redirect;       // Restart from the commit PC
    logic trap;           // Exception, eret or debug entry
    logic any_fence;      // fence or fence.i

    assign mispredict = resolved_branch_i.valid && resolved_branch_i.is_mispredict;
    assign any_fence  = fence_i || fence_i_i;
    assign redirect   = any_fence || sfence_vma_i || flush_csr_i || flush_commit_i;
    assign trap       = ex_valid_i || eret_i || set_debug_pc_i;

    // ------------------------------
    // Event decode
    // ------------------------------
    always_comb begin
        fence_active_d                 = fence_active_q;
        flush_dcache_d                 = 1'b0;
        flush_bus.set_pc_commit        = 1'b0;
        flush_bus.flush_if             = 1'b0;
        flush_bus.flush_unissued_instr = 1'b0;
        flush_bus.flush_id             = 1'b0;
        flush_bus.flush_ex             = 1'b0;
        flush_bus.flush_bp             = 1'b0;
        flush_bus.flush_icache         = 1'b0;
        flush_bus.flush_tlb            = 1'b0;

        // Wrong path only reached fetch and the scoreboard front
        if (mispredict) begin
            flush_bus.flush_if             = 1'b1;
            flush_bus.flush_unissued_instr = 1'b1;
        end

        // Serializing instructions restart right after themselves
        if (redirect) begin
            flush_bus.set_pc_commit        = 1'b1;
            flush_bus.flush_if             = 1'b1;
            flush_bus.flush_unissued_instr = 1'b1;
            flush_bus.flush_id             = 1'b1;
            flush_bus.flush_ex             = 1'b1;
        end

        if (fence_i_i)    flush_bus.flush_icache = 1'b1; // Fetched code may be stale
        if (sfence_vma_i) flush_bus.flush_tlb    = 1'b1; // Translations changed

        // ------------------------------
        // Fence handling
        // ------------------------------
        // Both fences push dirty lines out, the core waits for the walk
        if (any_fence) begin
            fence_active_d = 1'b1;
            flush_dcache_d = 1'b1;
        end

        if (fence_active_q) begin
            if (flush_dcache_ack_i) begin
                fence_active_d = 1'b0; // Walk finished, drop request next cycle
            end else begin
                flush_dcache_d = 1'b1; // Keep asking
            end
        end

        // Trap PC comes from the CSR file, not from commit
        if (trap) begin
            flush_bus.set_pc_commit        = 1'b0;
            flush_bus.flush_if             = 1'b1;
            flush_bus.flush_unissued_instr = 1'b1;
            flush_bus.flush_id             = 1'b1;
            flush_bus.flush_ex             = 1'b1;
            flush_bus.flush_bp             = 1'b1; // No speculative fetch across privilege change
        end
    end

    // ------------------------------
    // Halt
    // ------------------------------
    assign halt_o = halt_csr_i || halt_acc_i || fence_active_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            fence_active_q <= 1'b0;
            flush_dcache_o <= 1'b0;
        end else begin
            fence_active_q <= fence_active_d;
            flush_dcache_o <= flush_dcache_d; // Registered, long route to the cache
        end
    end

endmodule

// ==== logic/dcache_flush_engine.sv ====
// Dcache flush engine: tracks dirty sets and writes them back over a credited port on request
`timescale 1ns/100ps

module dcache_flush_engine (
    input  logic                             clk_i,
    input  logic                             rst_ni,
    input  logic                             mark_dirty_i, // Store hit a set
    input  logic [flush_pkg::DCACHE_IDX_W-1:0] mark_idx_i,
    input  logic                             flush_req_i,  // Level request from the controller
    output logic                             flush_ack_o,  // One cycle after the last set
    output logic                             wb_valid_o,   // Write-back issued, spends a credit
    output logic [flush_pkg::DCACHE_IDX_W-1:0] wb_idx_o,   // Set being written back
    input  logic                             wb_credit_i   // One credit returned
);

    import flush_pkg::*;

    typedef enum logic [1:0] {
        IDLE, // Recording stores
        WALK, // Scanning sets from 0 up
        ACK   // Report completion
    } state_e;

    state_e                  state_d, state_q;
    logic [DCACHE_SETS-1:0]  dirty_d, dirty_q;     // One bit per set
    logic [DCACHE_IDX_W-1:0] idx_d, idx_q;         // Walk pointer
    logic [WB_CNT_W-1:0]     credits_d, credits_q; // Write-backs we may still send
    logic                    has_credit;
    logic                    issue;                // Write-back this cycle
    logic                    step;                 // Current set done this cycle
    logic                    last_set;

    assign has_credit = credits_q != '0;
    assign last_set   = idx_q == DCACHE_IDX_W'(DCACHE_SETS - 1);
    assign issue      = (state_q == WALK) && dirty_q[idx_q] && has_credit;
    assign step       = (state_q == WALK) && (!dirty_q[idx_q] || has_credit); // Stall on dirty

    // ------------------------------
    // Credit counter
    // ------------------------------
    always_comb begin
        credits_d = credits_q;
        if (issue && !wb_credit_i) begin
            credits_d = credits_q - 1'b1;
        end else if (!issue && wb_credit_i && (credits_q != WB_CNT_W'(WB_CREDITS))) begin
            credits_d = credits_q + 1'b1; // Saturate at the reset value
        end
    end

    // ------------------------------
    // Walk FSM
    // ------------------------------
    always_comb begin
        state_d = state_q;
        idx_d   = idx_q;
        dirty_d = dirty_q;

        // Stores landing mid-walk are not tracked
        if (mark_dirty_i && (state_q != WALK)) dirty_d[mark_idx_i] = 1'b1;

        case (state_q)
            IDLE: begin
                if (flush_req_i) begin
                    state_d = WALK;
                    idx_d   = '0;
                end
            end
            WALK: begin
                if (step) begin
                    if (issue) dirty_d[idx_q] = 1'b0; // Line is clean once sent
                    if (last_set) begin
                        state_d = ACK;
                    end else begin
                        idx_d = idx_q + 1'b1;
                    end
                end
            end
            ACK:     state_d = IDLE; // Request drops before we look again
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q   <= IDLE;
            dirty_q   <= '0;
            idx_q     <= '0;
            credits_q <= WB_CNT_W'(WB_CREDITS);
        end else begin
            state_q   <= state_d;
            dirty_q   <= dirty_d;
            idx_q     <= idx_d;
            credits_q <= credits_d;
        end
    end

    // ------------------------------
    // Outputs
    // ------------------------------
    assign flush_ack_o = state_q == ACK;
    assign wb_valid_o  = issue;  // Never without a credit
    assign wb_idx_o    = idx_q;

endmodule

// ==== logic/flush_subsystem_top.sv ====
// Top level of the flush slice: wires branch check, flush controller and dcache flush engine
`timescale 1ns/100ps

module flush_subsystem_top (
    input  logic                             clk_i,
    input  logic                             rst_ni,
    // Branch resolution
    input  logic                             resolve_valid_i,
    input  logic [flush_pkg::XLEN-1:0]       pc_i,
    input  logic                             predicted_taken_i,
    input  logic                             actual_taken_i,
    input  logic [flush_pkg::XLEN-1:0]       predicted_target_i,
    input  logic [flush_pkg::XLEN-1:0]       actual_target_i,
    // Pipeline events
    input  logic                             fence_i,
    input  logic                             fence_i_i,
    input  logic                             sfence_vma_i,
    input  logic                             flush_csr_i,
    input  logic                             flush_commit_i,
    input  logic                             ex_valid_i,
    input  logic                             eret_i,
    input  logic                             set_debug_pc_i,
    input  logic                             halt_csr_i,
    input  logic                             halt_acc_i,
    // Store tracking
    input  logic                             mark_dirty_i,
    input  logic [flush_pkg::DCACHE_IDX_W-1:0] mark_idx_i,
    // Flush commands
    output logic                             set_pc_commit_o,
    output logic                             flush_if_o,
    output logic                             flush_unissued_instr_o,
    output logic                             flush_id_o,
    output logic                             flush_ex_o,
    output logic                             flush_bp_o,
    output logic                             flush_icache_o,
    output logic                             flush_tlb_o,
    output logic                             flush_dcache_o,
    output logic                             halt_o,
    // Write-back port
    output logic                             wb_valid_o,
    output logic [flush_pkg::DCACHE_IDX_W-1:0] wb_idx_o,
    input  logic                             wb_credit_i
);

    import flush_pkg::*;

    bp_resolve_t resolved_branch;   // Registered branch outcome
    logic        flush_dcache_ack;  // Walk done

    flush_bus_if flush_bus ();

    branch_resolve_unit u_branch_resolve (
        .clk_i              (clk_i),
        .rst_ni             (rst_ni),
        .resolve_valid_i    (resolve_valid_i),
        .pc_i               (pc_i),
        .predicted_taken_i  (predicted_taken_i),
        .actual_taken_i     (actual_taken_i),
        .predicted_target_i (predicted_target_i),
        .actual_target_i    (actual_target_i),
        .resolved_branch_o  (resolved_branch)
    );

    flush_ctrl u_flush_ctrl (
        .clk_i              (clk_i),
        .rst_ni             (rst_ni),
        .resolved_branch_i  (resolved_branch),
        .fence_i            (fence_i),
        .fence_i_i          (fence_i_i),
        .sfence_vma_i       (sfence_vma_i),
        .flush_csr_i        (flush_csr_i),
        .flush_commit_i     (flush_commit_i),
        .ex_valid_i         (ex_valid_i),
        .eret_i             (eret_i),
        .set_debug_pc_i     (set_debug_pc_i),
        .halt_csr_i         (halt_csr_i),
        .halt_acc_i         (halt_acc_i),
        .flush_dcache_ack_i (flush_dcache_ack),
        .flush_bus          (flush_bus.ctrl),
        .flush_dcache_o     (flush_dcache_o),
        .halt_o             (halt_o)
    );

    dcache_flush_engine u_dcache_flush (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .mark_dirty_i (mark_dirty_i),
        .mark_idx_i   (mark_idx_i),
        .flush_req_i  (flush_dcache_o),   // Same register that leaves the top
        .flush_ack_o  (flush_dcache_ack),
        .wb_valid_o   (wb_valid_o),
        .wb_idx_o     (wb_idx_o),
        .wb_credit_i  (wb_credit_i)
    );

    // ------------------------------
    // Flush bus out to the pins
    // ------------------------------
    assign set_pc_commit_o        = flush_bus.set_pc_commit;
    assign flush_if_o             = flush_bus.flush_if;
    assign flush_unissued_instr_o = flush_bus.flush_unissued_instr;
    assign flush_id_o             = flush_bus.flush_id;
    assign flush_ex_o             = flush_bus.flush_ex;
    assign flush_bp_o             = flush_bus.flush_bp;
    assign flush_icache_o         = flush_bus.flush_icache;
    assign flush_tlb_o            = flush_bus.flush_tlb;

endmodule

// ==== dv/flush_vectors.svh ====
// Single-cycle flush event table, included into the body of the flush slice testbench
`ifndef FLUSH_VECTORS_SVH
`define FLUSH_VECTORS_SVH

// Each row is {inputs[7:0], expected[8:0]}, MSB first
// Inputs   sfence_vma flush_csr flush_commit ex_valid eret set_debug_pc halt_csr halt_acc
// Expected set_pc_commit flush_if flush_unissued_instr flush_id flush_ex
//          flush_bp flush_icache flush_tlb halt
localparam int NUM_VECTORS = 12;

localparam logic [16:0] VECTORS [NUM_VECTORS] = '{
    {8'b0000_0000, 9'b000000000}, // Idle, nothing moves
    {8'b1000_0000, 9'b111110010}, // sfence.vma, redirect plus TLB
    {8'b0100_0000, 9'b111110000}, // CSR side effect, redirect
    {8'b0010_0000, 9'b111110000}, // Commit flush, redirect
    {8'b0001_0000, 9'b011111000}, // Exception, trap flush with predictor
    {8'b0000_1000, 9'b011111000}, // eret
    {8'b0000_0100, 9'b011111000}, // Debug entry
    {8'b0011_0000, 9'b011111000}, // Exception wins over commit flush
    {8'b1000_1000, 9'b011111010}, // eret with sfence.vma, TLB still flushed
    {8'b0000_0010, 9'b000000001}, // CSR halt only
    {8'b0000_0001, 9'b000000001}, // Accelerator halt only
    {8'b0100_0001, 9'b111110001}  // CSR flush while halted
};

`endif

// ==== dv/tb_flush_subsystem.sv ====
// Testbench for the flush slice; compile through sources.f with tb_flush_subsystem as top
`timescale 1ns/100ps

module tb_flush_subsystem;

    import flush_pkg::*;

    localparam int unsigned SEED       = 32'h5f01b522;
    localparam int          WAIT_LIMIT = 200; // Cycles any single wait may take

    // ------------------------------
    // DUT signals, named after its ports
    // ------------------------------
    logic                    clk_i, rst_ni;
    logic                    resolve_valid_i, predicted_taken_i, actual_taken_i;
    logic [XLEN-1:0]         pc_i, predicted_target_i, actual_target_i;
    logic                    fence_i, fence_i_i, sfence_vma_i, flush_csr_i, flush_commit_i;
    logic                    ex_valid_i, eret_i, set_debug_pc_i, halt_csr_i, halt_acc_i;
    logic                    mark_dirty_i, wb_credit_i, wb_valid_o;
    logic [DCACHE_IDX_W-1:0] mark_idx_i, wb_idx_o;
    logic                    set_pc_commit_o, flush_if_o, flush_unissued_instr_o, flush_id_o;
    logic                    flush_ex_o, flush_bp_o, flush_icache_o, flush_tlb_o;
    logic                    flush_dcache_o, halt_o;

    int                      errors = 0;
    int                      tests  = 0;
    int                      failed = 0;
    int                      pending [$];          // Cycles left before each credit goes home
    logic [DCACHE_IDX_W-1:0] wb_seen [$];          // Write-backs in the order they left
    logic                    hold_credits = 1'b0;  // Memory stops returning credits
    string                   out_name [9] = '{
        "set_pc_commit_o", "flush_if_o", "flush_unissued_instr_o", "flush_id_o", "flush_ex_o",
        "flush_bp_o", "flush_icache_o", "flush_tlb_o", "halt_o"
    };

    `include "flush_vectors.svh"

    flush_subsystem_top dut_i (.*);

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i; // 4 ns period
    end

    initial begin
        #20000;
        $display("simulation ran past its time limit");
        $display("RESULT: FAIL");
        $finish;
    end

    // ------------------------------
    // Write-back memory model
    // ------------------------------
    initial begin
        int pick;
        wb_credit_i = 1'b0;
        forever begin
            @(negedge clk_i);
            pick = -1;
            foreach (pending[k]) begin
                if (pending[k] > 0) begin
                    pending[k]--;
                end else if (pick < 0 && !hold_credits) begin
                    pick = k;
                end
            end
            wb_credit_i = pick >= 0; // At most one credit home per cycle
            if (pick >= 0) pending.delete(pick);
            if (wb_valid_o) begin
                assert (halt_o) else begin
                    $display("write-back of set %0d left while the core was not halted", wb_idx_o);
                    errors++;
                end
                // Outstanding in the engine's view, this one not counted yet
                assert (pending.size() + int'(wb_credit_i) < WB_CREDITS) else begin
                    $display("write-back issued with no credit left");
                    errors++;
                end
                wb_seen.push_back(wb_idx_o);
                pending.push_back(int'($urandom % 6)); // 0 to 5 cycles in memory
            end
        end
    end

    // ------------------------------
    // Helpers
    // ------------------------------
    task automatic expect_bit(input string sig, input logic got, input logic exp);
        assert (got === exp) else begin
            $display("ERR %s got 0x%0h expected 0x%0h", sig, got, exp);
            errors++;
        end
    endtask

    task automatic compare_word(input string sig, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("ERR %s got 0x%0h expected 0x%0h", sig, got, exp);
            errors++;
        end
    endtask

    task automatic finish_test(input string name, input int err_at_start);
        tests++;
        if (errors == err_at_start) begin
            $display("test %s: ok", name);
        end else begin
            failed++;
            $display("test %s: %0d errors", name, errors - err_at_start);
        end
    endtask

    task automatic apply_events(input logic [7:0] ev);
        sfence_vma_i   = ev[7];
        flush_csr_i    = ev[6];
        flush_commit_i = ev[5];
        ex_valid_i     = ev[4];
        eret_i         = ev[3];
        set_debug_pc_i = ev[2];
        halt_csr_i     = ev[1];
        halt_acc_i     = ev[0];
    endtask

    task automatic clear_events();
        apply_events('0);
        fence_i            = 1'b0;
        fence_i_i          = 1'b0;
        resolve_valid_i    = 1'b0;
        pc_i               = '0;
        predicted_taken_i  = 1'b0;
        actual_taken_i     = 1'b0;
        predicted_target_i = '0;
        actual_target_i    = '0;
        mark_dirty_i       = 1'b0;
        mark_idx_i         = '0;
    endtask

    task automatic wait_halt_drop();
        int n = 0;
        while (halt_o && n < WAIT_LIMIT) begin
            @(posedge clk_i);
            #1;
            n++;
        end
        assert (!halt_o) else begin
            $display("timeout, halt_o still high after %0d cycles", WAIT_LIMIT);
            errors++;
        end
    endtask

    task automatic wait_credits_home();
        int n = 0;
        while ((pending.size() != 0 || wb_credit_i) && n < WAIT_LIMIT) begin
            @(posedge clk_i);
            #1;
            n++;
        end
        assert (pending.size() == 0) else begin
            $display("timeout, write-back credits never came back");
            errors++;
        end
    endtask

    // Mispredict shows on the flush bus one cycle after resolve
    task automatic check_branch(input string name, input logic pt, input logic at,
                                input logic [XLEN-1:0] ptgt, input logic [XLEN-1:0] atgt,
                                input logic miss);
        int err0 = errors;
        @(negedge clk_i);
        resolve_valid_i    = 1'b1;
        pc_i               = 32'h0000_1f40;
        predicted_taken_i  = pt;
        actual_taken_i     = at;
        predicted_target_i = ptgt;
        actual_target_i    = atgt;
        #1;
        expect_bit("flush_if_o", flush_if_o, 1'b0); // Record not out yet
        @(posedge clk_i);
        #1;
        expect_bit("flush_if_o", flush_if_o, miss);
        expect_bit("flush_unissued_instr_o", flush_unissued_instr_o, miss);
        expect_bit("flush_id_o", flush_id_o, 1'b0);
        expect_bit("set_pc_commit_o", set_pc_commit_o, 1'b0);
        @(negedge clk_i);
        resolve_valid_i = 1'b0;
        @(posedge clk_i);
        #1;
        expect_bit("flush_if_o", flush_if_o, 1'b0); // Single cycle only
        finish_test(name, err0);
    endtask

    // Mark sets dirty, fence, then follow the walk to the halt release
    task automatic run_fence_walk(input string name, input logic [DCACHE_SETS-1:0] mask,
                                  input logic use_fence_i, input logic hold);
        int                      err0 = errors;
        logic [DCACHE_IDX_W-1:0] exp_q [$];
        wait_credits_home();
        hold_credits = hold;
        for (int i = 0; i < DCACHE_SETS; i++) begin
            if (mask[0]) begin
                exp_q.push_back(DCACHE_IDX_W'(i)); // Walk goes from set 0 up
                @(negedge clk_i);
                mark_dirty_i = 1'b1;
                mark_idx_i   = DCACHE_IDX_W'(i);
            end
            mask = mask >> 1;
        end
        @(negedge clk_i);
        mark_dirty_i = 1'b0;
        wb_seen.delete();
        fence_i   = !use_fence_i;
        fence_i_i = use_fence_i;
        #1;
        expect_bit("set_pc_commit_o", set_pc_commit_o, 1'b1);
        expect_bit("flush_ex_o", flush_ex_o, 1'b1);
        expect_bit("flush_icache_o", flush_icache_o, use_fence_i);
        expect_bit("halt_o", halt_o, 1'b0);
        @(posedge clk_i);
        #1;
        expect_bit("halt_o", halt_o, 1'b1);                 // Fence active from the next cycle
        expect_bit("flush_dcache_o", flush_dcache_o, 1'b1);
        @(negedge clk_i);
        fence_i   = 1'b0;
        fence_i_i = 1'b0;
        if (hold) begin
            repeat (3 * DCACHE_SETS) @(posedge clk_i);       // Walk reaches its stall well before
            #1;
            compare_word("wb_valid_o count with credits held", wb_seen.size(), WB_CREDITS);
            expect_bit("halt_o", halt_o, 1'b1);
            hold_credits = 1'b0;
        end
        wait_halt_drop();
        expect_bit("flush_dcache_o", flush_dcache_o, 1'b0);
        compare_word("wb_valid_o count", wb_seen.size(), exp_q.size());
        foreach (exp_q[k]) begin
            if (k < wb_seen.size()) begin
                compare_word("wb_idx_o", 32'(wb_seen[k]), 32'(exp_q[k]));
            end
        end
        finish_test(name, err0);
    endtask

    // ------------------------------
    // Test sequence
    // ------------------------------
    initial begin
        logic [31:0]            rnd;
        logic [DCACHE_SETS-1:0] mask;
        logic [16:0]            row;
        logic [8:0]             obs;
        logic [8:0]             exp;
        int                     err0;
        void'($urandom(SEED));
        rst_ni = 1'b0;
        clear_events();
        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;

        for (int r = 0; r < NUM_VECTORS; r++) begin
            err0 = errors;
            row  = VECTORS[r];
            @(negedge clk_i);
            apply_events(row[16:9]);
            @(posedge clk_i);
            #1;
            obs = {set_pc_commit_o, flush_if_o, flush_unissued_instr_o, flush_id_o, flush_ex_o,
                   flush_bp_o, flush_icache_o, flush_tlb_o, halt_o};
            exp = row[8:0];
            foreach (out_name[b]) begin
                expect_bit(out_name[b], obs[8], exp[8]); // MSB first, shifted up each step
                obs = obs << 1;
                exp = exp << 1;
            end
            finish_test($sformatf("event_row_%0d", r), err0);
        end
        @(negedge clk_i);
        clear_events();

        check_branch("branch_taken_not", 1'b1, 1'b0, 32'h0000_2000, 32'h0000_2000, 1'b1);
        check_branch("branch_not_taken", 1'b0, 1'b1, 32'h0000_2000, 32'h0000_2000, 1'b1);
        check_branch("branch_target", 1'b1, 1'b1, 32'h0000_2000, 32'h0000_2400, 1'b1);
        check_branch("branch_taken_ok", 1'b1, 1'b1, 32'h0000_2000, 32'h0000_2000, 1'b0);
        check_branch("branch_not_ok", 1'b0, 1'b0, 32'h0000_2000, 32'h0000_3000, 1'b0);

        run_fence_walk("fence_i_clean", '0, 1'b1, 1'b0);
        rnd  = $urandom;
        mask = rnd[DCACHE_SETS-1:0];
        if (mask == '0) mask = 16'h8001;
        run_fence_walk("fence_dirty_walk", mask, 1'b0, 1'b0);
        run_fence_walk("credit_hold", 16'h1a46, 1'b0, 1'b1);

        $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+dv
logic/flush_pkg.sv
logic/flush_bus_if.sv
logic/branch_resolve_unit.sv
logic/flush_ctrl.sv
logic/dcache_flush_engine.sv
logic/flush_subsystem_top.sv
dv/tb_flush_subsystem.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the flush slice testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module tb_flush_subsystem -f sources.f -o tb_sim
./obj_dir/tb_sim > sim.log 2>&1
cat sim.log

if grep -qx "RESULT: PASS" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
